// File: list.f
+incdir+src
src/up_bus_pkg.sv
src/dac_tpl_pkg.sv
src/up_bus_if.sv
src/up_axi_bridge.sv
src/up_dac_common.sv
src/up_dac_channel.sv
src/dac_tpl_regmap.sv
bench/dac_tpl_regmap_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the register map testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
  --top-module dac_tpl_regmap_tb -f list.f -o dac_tpl_regmap_sim
./obj_dir/dac_tpl_regmap_sim | tee sim.log

if grep -q "^Test OK$" sim.log; then
  echo "simulation passed"
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi

// File: bench/dac_tpl_regmap_tb.sv
// ********************************************************
// table-driven AXI4-Lite testbench for two channels and ID 5
// handshakes are sampled at the rising edge and inputs change on the falling edge
// ********************************************************

`timescale 1ns/100ps

`include "dac_tpl_macros.svh"

module dac_tpl_regmap_tb;

  localparam int NUM_CH     = 2;
  localparam int WAIT_LIMIT = 100;
  localparam int MAX_TESTS  = 128;

  typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_PORT, OP_IDLE, OP_STALL} op_t;

  // port selectors for OP_PORT carry the channel in bits 7..4
  // selectors 0..7 pick the 16 bit slices
  localparam logic [3:0] P_DATA_SEL = 4'd8;
  localparam logic [3:0] P_FORMAT   = 4'd9;
  localparam logic [3:0] P_SYNCS    = 4'd10;
  localparam logic [3:0] P_ANY      = 4'd11;

  logic                 up_clk;
  logic                 up_rstn;
  logic                 s_axi_awvalid, s_axi_awready;
  logic [15:0]          s_axi_awaddr, s_axi_araddr;
  logic                 s_axi_wvalid, s_axi_wready;
  logic [31:0]          s_axi_wdata, s_axi_rdata;
  logic [3:0]           s_axi_wstrb;
  logic                 s_axi_bvalid, s_axi_bready;
  logic [1:0]           s_axi_bresp, s_axi_rresp;
  logic                 s_axi_arvalid, s_axi_arready;
  logic                 s_axi_rvalid, s_axi_rready;
  logic                 dac_dunf, dac_sync, dac_dds_format;
  logic [NUM_CH*4-1:0]  dac_data_sel;
  logic [NUM_CH*16-1:0] dac_dds_scale_0, dac_dds_init_0, dac_dds_incr_0;
  logic [NUM_CH*16-1:0] dac_dds_scale_1, dac_dds_init_1, dac_dds_incr_1;
  logic [NUM_CH*16-1:0] dac_pat_data_0, dac_pat_data_1;

  // stimulus table
  string       t_name  [MAX_TESTS];
  op_t         t_op    [MAX_TESTS];
  logic [15:0] t_addr  [MAX_TESTS];
  logic [31:0] t_wdata [MAX_TESTS];
  logic        t_dunf  [MAX_TESTS];
  logic [31:0] t_exp   [MAX_TESTS];
  logic [1:0]  t_resp  [MAX_TESTS];
  int          n_tests;
  int          n_pass;
  int          n_fail;
  int          sync_count;
  logic [31:0] lcg_state;

  dac_tpl_regmap #(.ID(5), .NUM_CHANNELS(NUM_CH)) dac_tpl_regmap_i (
    .up_clk(up_clk), .up_rstn(up_rstn),
    .s_axi_awvalid(s_axi_awvalid), .s_axi_awready(s_axi_awready), .s_axi_awaddr(s_axi_awaddr),
    .s_axi_wvalid(s_axi_wvalid), .s_axi_wready(s_axi_wready), .s_axi_wdata(s_axi_wdata),
    .s_axi_wstrb(s_axi_wstrb),
    .s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready), .s_axi_bresp(s_axi_bresp),
    .s_axi_arvalid(s_axi_arvalid), .s_axi_arready(s_axi_arready), .s_axi_araddr(s_axi_araddr),
    .s_axi_rvalid(s_axi_rvalid), .s_axi_rready(s_axi_rready), .s_axi_rdata(s_axi_rdata),
    .s_axi_rresp(s_axi_rresp),
    .dac_dunf(dac_dunf), .dac_sync(dac_sync), .dac_dds_format(dac_dds_format),
    .dac_data_sel(dac_data_sel),
    .dac_dds_scale_0(dac_dds_scale_0), .dac_dds_init_0(dac_dds_init_0),
    .dac_dds_incr_0(dac_dds_incr_0), .dac_dds_scale_1(dac_dds_scale_1),
    .dac_dds_init_1(dac_dds_init_1), .dac_dds_incr_1(dac_dds_incr_1),
    .dac_pat_data_0(dac_pat_data_0), .dac_pat_data_1(dac_pat_data_1)
  );

  always #50 up_clk = ~up_clk;

  // each one-cycle sync pulse is seen at exactly one falling edge
  always @(negedge up_clk) begin
    if (!up_rstn) begin
      sync_count = 0;
    end else if (dac_sync) begin
      sync_count = sync_count + 1;
    end
  end

  function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] port_value(input logic [7:0] sel);
    int ch;
    ch = int'(sel[7:4]);
    case (sel[3:0])
      4'd0:       return {16'd0, dac_dds_scale_0[16*ch +: 16]};
      4'd1:       return {16'd0, dac_dds_init_0[16*ch +: 16]};
      4'd2:       return {16'd0, dac_dds_incr_0[16*ch +: 16]};
      4'd3:       return {16'd0, dac_dds_scale_1[16*ch +: 16]};
      4'd4:       return {16'd0, dac_dds_init_1[16*ch +: 16]};
      4'd5:       return {16'd0, dac_dds_incr_1[16*ch +: 16]};
      4'd6:       return {16'd0, dac_pat_data_0[16*ch +: 16]};
      4'd7:       return {16'd0, dac_pat_data_1[16*ch +: 16]};
      P_DATA_SEL: return {28'd0, dac_data_sel[4*ch +: 4]};
      P_FORMAT:   return {31'd0, dac_dds_format};
      P_SYNCS:    return 32'(sync_count);
      default:    return {31'd0, |{dac_sync, dac_dds_format, dac_data_sel, dac_dds_scale_0,
                                   dac_dds_init_0, dac_dds_incr_0, dac_dds_scale_1,
                                   dac_dds_init_1, dac_dds_incr_1, dac_pat_data_0,
                                   dac_pat_data_1}};
    endcase
  endfunction

  task automatic add_test(input string name, input op_t op, input logic [15:0] addr,
                          input logic [31:0] wdata, input logic dunf,
                          input logic [31:0] exp, input logic [1:0] resp);
    t_name[n_tests]  = name;
    t_op[n_tests]    = op;
    t_addr[n_tests]  = addr;
    t_wdata[n_tests] = wdata;
    t_dunf[n_tests]  = dunf;
    t_exp[n_tests]   = exp;
    t_resp[n_tests]  = resp;
    n_tests++;
  endtask

  task automatic build_table();
    logic [31:0] v;
    logic [31:0] rd;
    logic [15:0] base;
    logic [15:0] exp_slice [NUM_CH][9];
    for (int c = 0; c < NUM_CH; c++) begin
      for (int p = 0; p < 9; p++) begin
        exp_slice[c][p] = '0;
      end
    end
    n_tests = 0;
    add_test("version", OP_READ, 16'h0000, '0, 1'b0, `DAC_TPL_VERSION, `AXI_RESP_OKAY);
    add_test("id", OP_READ, 16'h0004, '0, 1'b0, 32'd5, `AXI_RESP_OKAY);
    add_test("outputs_zero", OP_PORT, {8'd0, 4'd0, P_ANY}, '0, 1'b0, '0, `AXI_RESP_OKAY);
    v = rand_word();
    add_test("scratch_wr", OP_WRITE, 16'h0008, v, 1'b0, '0, `AXI_RESP_OKAY);
    add_test("scratch_rd", OP_READ, 16'h0008, '0, 1'b0, v, `AXI_RESP_OKAY);
    // ********************************************************
    // channel pages at word 0x100 + 0x10 * ch
    // ********************************************************
    for (int ch = 0; ch < NUM_CH; ch++) begin
      base = 16'h0400 + 16'(ch * 'h40);
      for (int r = 0; r < 7; r++) begin
        if (r != 5) begin
          v = rand_word();
          add_test($sformatf("ch%0d_reg%0d_wr", ch, r), OP_WRITE, base + 16'(r * 4), v,
                   1'b0, '0, `AXI_RESP_OKAY);
          case (r)
            0: exp_slice[ch][0] = v[15:0];
            1: begin
              exp_slice[ch][1] = v[31:16];
              exp_slice[ch][2] = v[15:0];
            end
            2: exp_slice[ch][3] = v[15:0];
            3: begin
              exp_slice[ch][4] = v[31:16];
              exp_slice[ch][5] = v[15:0];
            end
            4: begin
              exp_slice[ch][7] = v[31:16];
              exp_slice[ch][6] = v[15:0];
            end
            default: exp_slice[ch][8] = {12'd0, v[3:0]};
          endcase
          if (r == 1 || r == 3 || r == 4) begin
            rd = v;
          end else if (r == 6) begin
            rd = {28'd0, v[3:0]};
          end else begin
            rd = {16'd0, v[15:0]};
          end
          add_test($sformatf("ch%0d_reg%0d_rd", ch, r), OP_READ, base + 16'(r * 4), '0,
                   1'b0, rd, `AXI_RESP_OKAY);
        end
      end
      // check every slice of every channel so an untouched channel must hold its value
      for (int c = 0; c < NUM_CH; c++) begin
        for (int p = 0; p < 9; p++) begin
          add_test($sformatf("after_ch%0d_port_ch%0d_%0d", ch, c, p), OP_PORT,
                   {8'd0, 4'(c), 4'(p)}, '0, 1'b0, {16'd0, exp_slice[c][p]}, `AXI_RESP_OKAY);
        end
      end
    end
    add_test("sync_wr", OP_WRITE, 16'h0044, 32'h1, 1'b0, '0, `AXI_RESP_OKAY);
    add_test("sync_count", OP_PORT, {8'd0, P_SYNCS}, '0, 1'b0, 32'd1, `AXI_RESP_OKAY);
    add_test("sync_rd", OP_READ, 16'h0044, '0, 1'b0, '0, `AXI_RESP_OKAY);
    add_test("format_wr", OP_WRITE, 16'h0048, 32'h10, 1'b0, '0, `AXI_RESP_OKAY);
    add_test("format_port", OP_PORT, {8'd0, P_FORMAT}, '0, 1'b0, 32'd1, `AXI_RESP_OKAY);
    add_test("format_rd", OP_READ, 16'h0048, '0, 1'b0, 32'h10, `AXI_RESP_OKAY);
    add_test("sync_once", OP_PORT, {8'd0, P_SYNCS}, '0, 1'b0, 32'd1, `AXI_RESP_OKAY);
    // sticky underflow
    add_test("status_idle", OP_READ, 16'h0088, '0, 1'b0, '0, `AXI_RESP_OKAY);
    add_test("dunf_pulse", OP_IDLE, 16'h0000, '0, 1'b1, '0, `AXI_RESP_OKAY);
    add_test("status_set", OP_READ, 16'h0088, '0, 1'b0, 32'd1, `AXI_RESP_OKAY);
    add_test("status_sticky", OP_READ, 16'h0088, '0, 1'b0, 32'd1, `AXI_RESP_OKAY);
    add_test("status_w1c", OP_WRITE, 16'h0088, 32'h1, 1'b0, '0, `AXI_RESP_OKAY);
    add_test("status_clear", OP_READ, 16'h0088, '0, 1'b0, '0, `AXI_RESP_OKAY);
    // word 0x200 belongs to no block
    add_test("unmapped_rd", OP_READ, 16'h0800, '0, 1'b0, '0, `AXI_RESP_SLVERR);
    add_test("unmapped_wr", OP_WRITE, 16'h0800, rand_word(), 1'b0, '0, `AXI_RESP_SLVERR);
    v = rand_word();
    add_test("stall_wr", OP_STALL, 16'h0008, v, 1'b0, '0, `AXI_RESP_OKAY);
    add_test("stall_rd", OP_READ, 16'h0008, '0, 1'b0, v, `AXI_RESP_OKAY);
  endtask

  // ********************************************************
  // AXI4-Lite transfers
  // ********************************************************

  task automatic axi_write(input logic [15:0] addr, input logic [31:0] data, input int hold,
                           output logic [1:0] resp, output bit ok);
    int cnt;
    resp          = 2'b11;
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    s_axi_bready  = (hold == 0);
    cnt = 0;
    do begin
      @(posedge up_clk);
      cnt++;
    end while (!(s_axi_awready && s_axi_wready) && cnt < WAIT_LIMIT);
    ok = s_axi_awready && s_axi_wready;
    @(negedge up_clk);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    if (!ok) begin
      $display("awready and wready did not rise together for write to %h", addr);
    end else begin
      cnt = 0;
      do begin
        @(posedge up_clk);
        cnt++;
      end while (!s_axi_bvalid && cnt < WAIT_LIMIT);
      ok = s_axi_bvalid;
      if (!ok) begin
        $display("bvalid did not rise for write to %h", addr);
      end else if (hold > 0) begin
        repeat (hold) begin
          @(posedge up_clk);
          if (!s_axi_bvalid) begin
            ok = 1'b0;
          end
        end
        if (!ok) begin
          $display("bvalid dropped while bready was low");
        end
        @(negedge up_clk);
        s_axi_bready = 1'b1;
        @(posedge up_clk);
      end
      resp = s_axi_bresp;
      @(negedge up_clk);
    end
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [15:0] addr, output logic [31:0] data,
                          output logic [1:0] resp, output bit ok);
    int cnt;
    data          = '0;
    resp          = 2'b11;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    s_axi_rready  = 1'b1;
    cnt = 0;
    do begin
      @(posedge up_clk);
      cnt++;
    end while (!s_axi_arready && cnt < WAIT_LIMIT);
    ok = s_axi_arready;
    @(negedge up_clk);
    s_axi_arvalid = 1'b0;
    if (!ok) begin
      $display("arready did not rise for read of %h", addr);
    end else begin
      cnt = 0;
      do begin
        @(posedge up_clk);
        cnt++;
      end while (!s_axi_rvalid && cnt < WAIT_LIMIT);
      ok   = s_axi_rvalid;
      data = s_axi_rdata;
      resp = s_axi_rresp;
      if (!ok) begin
        $display("rvalid did not rise for read of %h", addr);
      end
      @(negedge up_clk);
    end
    s_axi_rready = 1'b0;
  endtask

  task automatic run_test(input int i);
    logic [31:0] got;
    logic [1:0]  resp;
    bit          ok;
    bit          pass;
    got  = '0;
    resp = `AXI_RESP_OKAY;
    ok   = 1'b1;
    @(negedge up_clk);
    dac_dunf = t_dunf[i];
    case (t_op[i])
      OP_WRITE: axi_write(t_addr[i], t_wdata[i], 0, resp, ok);
      OP_STALL: axi_write(t_addr[i], t_wdata[i], 10, resp, ok);
      OP_READ:  axi_read(t_addr[i], got, resp, ok);
      OP_PORT:  got = port_value(t_addr[i][7:0]);
      default:  @(negedge up_clk);
    endcase
    dac_dunf = 1'b0;
    pass = ok;
    if ((t_op[i] == OP_READ || t_op[i] == OP_PORT) && got !== t_exp[i]) begin
      $display("Mismatch %s: expected %h, actual %h", t_name[i], t_exp[i], got);
      pass = 1'b0;
    end
    if (t_op[i] != OP_PORT && t_op[i] != OP_IDLE && resp !== t_resp[i]) begin
      $display("Mismatch %s response: expected %0d, actual %0d", t_name[i], t_resp[i], resp);
      pass = 1'b0;
    end
    if (pass) begin
      n_pass++;
      $display("PASS %s", t_name[i]);
    end else begin
      n_fail++;
      $display("FAIL %s", t_name[i]);
    end
  endtask

  initial begin
    up_clk        = 1'b0;
    up_rstn       = 1'b0;
    s_axi_awvalid = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = 4'hf;
    s_axi_bready  = 1'b0;
    s_axi_arvalid = 1'b0;
    s_axi_araddr  = '0;
    s_axi_rready  = 1'b0;
    dac_dunf      = 1'b0;
    n_pass        = 0;
    n_fail        = 0;
    lcg_state     = 32'h2981_e1d1;
    build_table();
    repeat (5) @(posedge up_clk);
    @(negedge up_clk);
    up_rstn = 1'b1;
    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    $display("%0d tests, %0d passed, %0d failed", n_tests, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: src/dac_tpl_regmap.sv
// ********************************************************
// register map of the DAC transport layer, single clock up_clk
// s_axi_wstrb is ignored, every write stores the full word
// ********************************************************

`timescale 1ns/100ps

module dac_tpl_regmap #(
  parameter int ID           = 0,
  parameter int NUM_CHANNELS = 2
) (
  input  logic                        up_clk,
  input  logic                        up_rstn,

  input  logic                        s_axi_awvalid,
  output logic                        s_axi_awready,
  input  up_bus_pkg::axi_addr_t       s_axi_awaddr,

  input  logic                        s_axi_wvalid,
  output logic                        s_axi_wready,
  input  up_bus_pkg::up_data_t        s_axi_wdata,
  input  logic [3:0]                  s_axi_wstrb,

  output logic                        s_axi_bvalid,
  input  logic                        s_axi_bready,
  output up_bus_pkg::axi_resp_t       s_axi_bresp,

  input  logic                        s_axi_arvalid,
  output logic                        s_axi_arready,
  input  up_bus_pkg::axi_addr_t       s_axi_araddr,

  output logic                        s_axi_rvalid,
  input  logic                        s_axi_rready,
  output up_bus_pkg::up_data_t        s_axi_rdata,
  output up_bus_pkg::axi_resp_t       s_axi_rresp,

  input  logic                        dac_dunf,
  output logic                        dac_sync,
  output logic                        dac_dds_format,
  output logic [NUM_CHANNELS*4-1:0]   dac_data_sel,
  output logic [NUM_CHANNELS*16-1:0]  dac_dds_scale_0,
  output logic [NUM_CHANNELS*16-1:0]  dac_dds_init_0,
  output logic [NUM_CHANNELS*16-1:0]  dac_dds_incr_0,
  output logic [NUM_CHANNELS*16-1:0]  dac_dds_scale_1,
  output logic [NUM_CHANNELS*16-1:0]  dac_dds_init_1,
  output logic [NUM_CHANNELS*16-1:0]  dac_dds_incr_1,
  output logic [NUM_CHANNELS*16-1:0]  dac_pat_data_0,
  output logic [NUM_CHANNELS*16-1:0]  dac_pat_data_1
);

  import up_bus_pkg::*;

  // bus 0 is the common block, bus n+1 is channel n
  up_bus_if bridge_bus ();
  up_bus_if blk_bus [NUM_CHANNELS:0] ();

  logic [NUM_CHANNELS:0] wack_s;
  logic [NUM_CHANNELS:0] rack_s;
  up_data_t              rdata_s [NUM_CHANNELS+1];
  up_data_t              rdata_all;
  logic                  wack_q;
  logic                  rack_q;
  up_data_t              rdata_q;

  up_axi_bridge i_up_axi_bridge (
    .up_clk        (up_clk),
    .up_rstn       (up_rstn),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .bus           (bridge_bus)
  );

  // ********************************************************
  // request fan-out and response collection
  // ********************************************************

  for (genvar k = 0; k <= NUM_CHANNELS; k++) begin : g_fanout
    assign blk_bus[k].wreq  = bridge_bus.wreq;
    assign blk_bus[k].waddr = bridge_bus.waddr;
    assign blk_bus[k].wdata = bridge_bus.wdata;
    assign blk_bus[k].rreq  = bridge_bus.rreq;
    assign blk_bus[k].raddr = bridge_bus.raddr;
    assign wack_s[k]        = blk_bus[k].wack;
    assign rack_s[k]        = blk_bus[k].rack;
    assign rdata_s[k]       = blk_bus[k].rdata;
  end

  // idle blocks drive zero, so an OR selects the active one
  always_comb begin
    rdata_all = '0;
    for (int n = 0; n <= NUM_CHANNELS; n++) begin
      rdata_all = rdata_all | rdata_s[n];
    end
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      wack_q  <= 1'b0;
      rack_q  <= 1'b0;
      rdata_q <= '0;
    end else begin
      wack_q  <= |wack_s;
      rack_q  <= |rack_s;
      rdata_q <= rdata_all;
    end
  end

  assign bridge_bus.wack  = wack_q;
  assign bridge_bus.rack  = rack_q;
  assign bridge_bus.rdata = rdata_q;

  // ********************************************************
  // register blocks
  // ********************************************************

  up_dac_common #(
    .ID (ID)
  ) i_up_dac_common (
    .up_clk         (up_clk),
    .up_rstn        (up_rstn),
    .bus            (blk_bus[0]),
    .dac_dunf       (dac_dunf),
    .dac_sync       (dac_sync),
    .dac_dds_format (dac_dds_format)
  );

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_channel
    up_dac_channel #(
      .CHANNEL_ID (i)
    ) i_up_dac_channel (
      .up_clk          (up_clk),
      .up_rstn         (up_rstn),
      .bus             (blk_bus[i+1]),
      .dac_dds_scale_0 (dac_dds_scale_0[16*i+:16]),
      .dac_dds_init_0  (dac_dds_init_0[16*i+:16]),
      .dac_dds_incr_0  (dac_dds_incr_0[16*i+:16]),
      .dac_dds_scale_1 (dac_dds_scale_1[16*i+:16]),
      .dac_dds_init_1  (dac_dds_init_1[16*i+:16]),
      .dac_dds_incr_1  (dac_dds_incr_1[16*i+:16]),
      .dac_pat_data_0  (dac_pat_data_0[16*i+:16]),
      .dac_pat_data_1  (dac_pat_data_1[16*i+:16]),
      .dac_data_sel    (dac_data_sel[4*i+:4])
    );
  end

  // pages must not overlap, so one block answers at most
  a_single_ack: assert property (@(posedge up_clk) disable iff (!up_rstn)
    $onehot0(wack_s | rack_s));

endmodule

// File: src/up_dac_channel.sv
// ********************************************************
// per-channel DDS, pattern and data select registers
// page at UP_CHAN_BASE + CHANNEL_ID * UP_CHAN_STRIDE
// ********************************************************

`timescale 1ns/100ps

`include "dac_tpl_macros.svh"

module up_dac_channel #(
  parameter int CHANNEL_ID = 0
) (
  input  logic                   up_clk,
  input  logic                   up_rstn,
  up_bus_if.slave                bus,
  output dac_tpl_pkg::dds_word_t dac_dds_scale_0,
  output dac_tpl_pkg::dds_word_t dac_dds_init_0,
  output dac_tpl_pkg::dds_word_t dac_dds_incr_0,
  output dac_tpl_pkg::dds_word_t dac_dds_scale_1,
  output dac_tpl_pkg::dds_word_t dac_dds_init_1,
  output dac_tpl_pkg::dds_word_t dac_dds_incr_1,
  output dac_tpl_pkg::dds_word_t dac_pat_data_0,
  output dac_tpl_pkg::dds_word_t dac_pat_data_1,
  output dac_tpl_pkg::data_sel_t dac_data_sel
);

  import up_bus_pkg::*;
  import dac_tpl_pkg::*;

  localparam int       OFS_BITS  = $bits(chan_reg_offset_t);
  localparam up_addr_t CHAN_BASE = up_addr_t'(`UP_CHAN_BASE + CHANNEL_ID * `UP_CHAN_STRIDE);
  localparam up_addr_t CHAN_MASK = up_addr_t'(`UP_CHAN_STRIDE - 1);

  logic             wsel;
  logic             rsel;
  chan_reg_offset_t wofs;
  chan_reg_offset_t rofs;
  up_data_t         rdata_mux;

  assign wsel = bus.wreq && ((bus.waddr & ~CHAN_MASK) == CHAN_BASE);
  assign rsel = bus.rreq && ((bus.raddr & ~CHAN_MASK) == CHAN_BASE);
  assign wofs = chan_reg_offset_t'(bus.waddr[OFS_BITS-1:0]);
  assign rofs = chan_reg_offset_t'(bus.raddr[OFS_BITS-1:0]);

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      bus.wack        <= 1'b0;
      bus.rack        <= 1'b0;
      bus.rdata       <= '0;
      dac_dds_scale_0 <= '0;
      dac_dds_init_0  <= '0;
      dac_dds_incr_0  <= '0;
      dac_dds_scale_1 <= '0;
      dac_dds_init_1  <= '0;
      dac_dds_incr_1  <= '0;
      dac_pat_data_0  <= '0;
      dac_pat_data_1  <= '0;
      dac_data_sel    <= '0;
    end else begin
      bus.wack  <= wsel;
      bus.rack  <= rsel;
      bus.rdata <= rsel ? rdata_mux : '0;
      if (wsel) begin
        case (wofs)
          SCALE_0: dac_dds_scale_0 <= bus.wdata[15:0];
          INIT_INCR_0: begin
            dac_dds_init_0 <= bus.wdata[31:16];
            dac_dds_incr_0 <= bus.wdata[15:0];
          end
          SCALE_1: dac_dds_scale_1 <= bus.wdata[15:0];
          INIT_INCR_1: begin
            dac_dds_init_1 <= bus.wdata[31:16];
            dac_dds_incr_1 <= bus.wdata[15:0];
          end
          PATTERN: begin
            dac_pat_data_1 <= bus.wdata[31:16];
            dac_pat_data_0 <= bus.wdata[15:0];
          end
          DATA_SEL: dac_data_sel <= bus.wdata[3:0];
          default: ;
        endcase
      end
    end
  end

  // read back in the same packing as the writes
  always_comb begin
    case (rofs)
      SCALE_0:     rdata_mux = {16'd0, dac_dds_scale_0};
      INIT_INCR_0: rdata_mux = {dac_dds_init_0, dac_dds_incr_0};
      SCALE_1:     rdata_mux = {16'd0, dac_dds_scale_1};
      INIT_INCR_1: rdata_mux = {dac_dds_init_1, dac_dds_incr_1};
      PATTERN:     rdata_mux = {dac_pat_data_1, dac_pat_data_0};
      DATA_SEL:    rdata_mux = {28'd0, dac_data_sel};
      default:     rdata_mux = '0;
    endcase
  end

endmodule

// File: src/up_dac_common.sv
// ********************************************************
// common registers of the transport layer, page at UP_COMMON_BASE
// underflow is sticky until a one is written to status bit 0
// ********************************************************

`timescale 1ns/100ps

`include "dac_tpl_macros.svh"

module up_dac_common #(
  parameter int ID = 0
) (
  input  logic    up_clk,
  input  logic    up_rstn,
  up_bus_if.slave bus,
  input  logic    dac_dunf,
  output logic    dac_sync,
  output logic    dac_dds_format
);

  import up_bus_pkg::*;

  localparam int       OFS_BITS  = $clog2(`UP_COMMON_WORDS);
  localparam up_addr_t PAGE_MASK = up_addr_t'(`UP_COMMON_WORDS - 1);

  logic                wsel;
  logic                rsel;
  logic [OFS_BITS-1:0] wofs;
  logic [OFS_BITS-1:0] rofs;
  up_data_t            scratch;
  logic                dunf_sticky;
  logic                dunf_clr;
  up_data_t            rdata_mux;

  // page decode
  assign wsel = bus.wreq && ((bus.waddr & ~PAGE_MASK) == `UP_COMMON_BASE);
  assign rsel = bus.rreq && ((bus.raddr & ~PAGE_MASK) == `UP_COMMON_BASE);
  assign wofs = bus.waddr[OFS_BITS-1:0];
  assign rofs = bus.raddr[OFS_BITS-1:0];

  assign dunf_clr = wsel && (wofs == `UP_COMMON_STATUS) && bus.wdata[0];

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      bus.wack       <= 1'b0;
      bus.rack       <= 1'b0;
      bus.rdata      <= '0;
      scratch        <= '0;
      dac_sync       <= 1'b0;
      dac_dds_format <= 1'b0;
      dunf_sticky    <= 1'b0;
    end else begin
      bus.wack  <= wsel;
      bus.rack  <= rsel;
      bus.rdata <= rsel ? rdata_mux : '0;
      // one pulse per write of bit 0
      dac_sync  <= wsel && (wofs == `UP_COMMON_SYNC) && bus.wdata[0];
      if (wsel && (wofs == `UP_COMMON_SCRATCH)) begin
        scratch <= bus.wdata;
      end
      if (wsel && (wofs == `UP_COMMON_FORMAT)) begin
        dac_dds_format <= bus.wdata[4];
      end
      // a new underflow wins over a clear in the same cycle
      dunf_sticky <= dac_dunf | (dunf_sticky & ~dunf_clr);
    end
  end

  // read back
  always_comb begin
    case (rofs)
      `UP_COMMON_VERSION: rdata_mux = `DAC_TPL_VERSION;
      `UP_COMMON_ID:      rdata_mux = up_data_t'(ID);
      `UP_COMMON_SCRATCH: rdata_mux = scratch;
      `UP_COMMON_FORMAT:  rdata_mux = {27'd0, dac_dds_format, 4'd0};
      `UP_COMMON_STATUS:  rdata_mux = {31'd0, dunf_sticky};
      default:            rdata_mux = '0;
    endcase
  end

endmodule

// File: src/up_axi_bridge.sv
// ********************************************************
// AXI4-Lite slave, one transaction at a time, writes before reads
// no ack within the timeout gives SLVERR; write strobes are ignored
// ********************************************************

`timescale 1ns/100ps

`include "dac_tpl_macros.svh"

module up_axi_bridge (
  input  logic                  up_clk,
  input  logic                  up_rstn,

  input  logic                  s_axi_awvalid,
  output logic                  s_axi_awready,
  input  up_bus_pkg::axi_addr_t s_axi_awaddr,

  input  logic                  s_axi_wvalid,
  output logic                  s_axi_wready,
  input  up_bus_pkg::up_data_t  s_axi_wdata,

  output logic                  s_axi_bvalid,
  input  logic                  s_axi_bready,
  output up_bus_pkg::axi_resp_t s_axi_bresp,

  input  logic                  s_axi_arvalid,
  output logic                  s_axi_arready,
  input  up_bus_pkg::axi_addr_t s_axi_araddr,

  output logic                  s_axi_rvalid,
  input  logic                  s_axi_rready,
  output up_bus_pkg::up_data_t  s_axi_rdata,
  output up_bus_pkg::axi_resp_t s_axi_rresp,

  up_bus_if.master              bus
);

  import up_bus_pkg::*;

  localparam int TO_BITS = $clog2(`UP_ACK_TIMEOUT);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_REQ,
    ST_WR_WAIT,
    ST_WR_RESP,
    ST_RD_REQ,
    ST_RD_WAIT,
    ST_RD_RESP
  } state_t;

  state_t             state;
  logic [TO_BITS-1:0] to_cnt;
  logic               timeout;
  logic               wr_start;
  logic               rd_start;
  up_addr_t           addr_q;
  up_data_t           wdata_q;

  // ********************************************************
  // AXI accept, write wins over read
  // ********************************************************

  assign wr_start = (state == ST_IDLE) && s_axi_awvalid && s_axi_wvalid;
  assign rd_start = (state == ST_IDLE) && s_axi_arvalid && !(s_axi_awvalid && s_axi_wvalid);

  assign s_axi_awready = wr_start;
  assign s_axi_wready  = wr_start;
  assign s_axi_arready = rd_start;
  assign s_axi_bvalid  = (state == ST_WR_RESP);
  assign s_axi_rvalid  = (state == ST_RD_RESP);

  // bus side
  assign bus.wreq  = (state == ST_WR_REQ);
  assign bus.rreq  = (state == ST_RD_REQ);
  assign bus.waddr = addr_q;
  assign bus.raddr = addr_q;
  assign bus.wdata = wdata_q;

  assign timeout = (to_cnt == TO_BITS'(`UP_ACK_TIMEOUT - 1));

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      state  <= ST_IDLE;
      to_cnt <= '0;
    end else begin
      to_cnt <= '0;
      case (state)
        ST_IDLE: begin
          if (wr_start) begin
            state <= ST_WR_REQ;
          end else if (rd_start) begin
            state <= ST_RD_REQ;
          end
        end
        ST_WR_REQ: state <= ST_WR_WAIT;
        ST_WR_WAIT: begin
          if (bus.wack || timeout) begin
            state <= ST_WR_RESP;
          end else begin
            to_cnt <= to_cnt + 1'b1;
          end
        end
        ST_WR_RESP: begin
          if (s_axi_bready) begin
            state <= ST_IDLE;
          end
        end
        ST_RD_REQ: state <= ST_RD_WAIT;
        ST_RD_WAIT: begin
          if (bus.rack || timeout) begin
            state <= ST_RD_RESP;
          end else begin
            to_cnt <= to_cnt + 1'b1;
          end
        end
        ST_RD_RESP: begin
          if (s_axi_rready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // captured address, data and responses
  always_ff @(posedge up_clk) begin
    if (wr_start) begin
      addr_q  <= s_axi_awaddr[15:2];
      wdata_q <= s_axi_wdata;
    end else if (rd_start) begin
      addr_q <= s_axi_araddr[15:2];
    end
    if ((state == ST_WR_WAIT) && (bus.wack || timeout)) begin
      s_axi_bresp <= bus.wack ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
    end
    if ((state == ST_RD_WAIT) && (bus.rack || timeout)) begin
      s_axi_rresp <= bus.rack ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
      s_axi_rdata <= bus.rack ? bus.rdata : '0;
    end
  end

  // ********************************************************
  // protocol checks
  // ********************************************************

  a_req_exclusive: assert property (@(posedge up_clk) disable iff (!up_rstn)
    !(bus.wreq && bus.rreq));

  a_bvalid_hold: assert property (@(posedge up_clk) disable iff (!up_rstn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp));

  a_rvalid_hold: assert property (@(posedge up_clk) disable iff (!up_rstn)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

// File: src/up_bus_if.sv
// ********************************************************
// one request/acknowledge register bus
// requests and acks are single-cycle pulses, rdata is 0 without rack
// ********************************************************

`timescale 1ns/100ps

interface up_bus_if;

  import up_bus_pkg::*;

  // write channel
  logic     wreq;
  up_addr_t waddr;
  up_data_t wdata;
  logic     wack;

  // read channel
  logic     rreq;
  up_addr_t raddr;
  up_data_t rdata;
  logic     rack;

  modport master (
    output wreq, waddr, wdata, rreq, raddr,
    input  wack, rack, rdata
  );

  modport slave (
    input  wreq, waddr, wdata, rreq, raddr,
    output wack, rack, rdata
  );

endinterface

// File: src/dac_tpl_pkg.sv
// ********************************************************
// types of the DAC control words and channel register offsets
// offsets 5 and 7..15 are unused and read as zero
// ********************************************************

package dac_tpl_pkg;

  // dds scale, phase, increment or pattern sample
  typedef logic [15:0] dds_word_t;

  // data source select of one channel
  typedef logic [3:0] data_sel_t;

  // register offsets inside one channel page
  typedef enum logic [3:0] {
    SCALE_0     = 4'd0,
    // init in 31..16, increment in 15..0
    INIT_INCR_0 = 4'd1,
    SCALE_1     = 4'd2,
    INIT_INCR_1 = 4'd3,
    // pattern 1 in 31..16, pattern 0 in 15..0
    PATTERN     = 4'd4,
    DATA_SEL    = 4'd6
  } chan_reg_offset_t;

endpackage

// File: src/up_bus_pkg.sv
// ********************************************************
// types of the internal register bus and the AXI4-Lite port
// bus addresses are word addresses, AXI addresses are bytes
// ********************************************************

package up_bus_pkg;

  // word address, AXI byte address bits 15..2
  typedef logic [13:0] up_addr_t;

  // one register word
  typedef logic [31:0] up_data_t;

  // AXI byte address
  typedef logic [15:0] axi_addr_t;

  // AXI response code
  typedef logic [1:0] axi_resp_t;

endpackage

// File: src/dac_tpl_macros.svh
// ********************************************************
// fixed constants of the register map; word addresses are 14 bits
// the channel stride must stay 16 words to match the offset enum
// ********************************************************

`ifndef DAC_TPL_MACROS_SVH
`define DAC_TPL_MACROS_SVH

// core version, read at word 0x000
`define DAC_TPL_VERSION 32'h0001_0261

// cycles the bridge waits for an acknowledge
`define UP_ACK_TIMEOUT 32

// common page
`define UP_COMMON_BASE 14'h000
`define UP_COMMON_WORDS 256

// channel pages, one per channel
`define UP_CHAN_BASE 14'h100
`define UP_CHAN_STRIDE 16

// common register offsets inside the common page
`define UP_COMMON_VERSION 8'h00
`define UP_COMMON_ID 8'h01
`define UP_COMMON_SCRATCH 8'h02
`define UP_COMMON_SYNC 8'h11
`define UP_COMMON_FORMAT 8'h12
`define UP_COMMON_STATUS 8'h22

// AXI response codes
`define AXI_RESP_OKAY 2'b00
`define AXI_RESP_SLVERR 2'b10

`endif
